//--- Bender.yml
package:
  name: cpuCore

sources:
  - design/cpuPkg.sv
  - design/sequencer.sv
  - design/fetchUnit.sv
  - design/aluUnit.sv
  - design/registerFile.sv
  - design/cpuCore.sv
  - target: test
    files:
      - dv/sysBusMemory.sv
      - dv/cpuCoreTb.sv

//--- cpuCore.f
design/cpuPkg.sv
design/sequencer.sv
design/fetchUnit.sv
design/aluUnit.sv
design/registerFile.sv
design/cpuCore.sv
dv/sysBusMemory.sv
dv/cpuCoreTb.sv

//--- design/aluUnit.sv
`timescale 1ns/100ps

module aluUnit import cpuPkg::*; (
   input  logic  Clock,
   input  logic  nReset,
   input  ctrl_t Ctrl,
   input  word_t Instr,
   input  word_t ReadData1,
   input  word_t ReadData2,
   output word_t Result,
   output logic  Carry
);

   word_t       immExt;
   word_t       operand2;
   logic        carryIn;
   logic [16:0] sum;
   logic        carryFlag;

   always_comb begin
      if (Ctrl.immSel == ImmZext8) begin
         immExt = {{(15 - Imm8Msb){1'b0}}, Instr[Imm8Msb:0]};
      end else begin
         immExt = {{(15 - Imm5Msb){Instr[Imm5Msb]}}, Instr[Imm5Msb:0]};
      end
   end

   assign operand2 = (Ctrl.op2Sel == Op2Imm) ? immExt : ReadData2;
   assign carryIn  = Ctrl.useCarry & carryFlag;

   always_comb begin
      case (Ctrl.aluFunc)
         FnADD:   sum = {1'b0, ReadData1} + {1'b0, operand2} + 17'(carryIn);
         default: sum = {1'b0, ReadData1};
      endcase
   end

   assign Result = sum[15:0];
   assign Carry  = sum[16];   // New carry, ahead of the flag register

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         carryFlag <= 1'b0;
      end else if (Ctrl.flagWe) begin
         carryFlag <= sum[16];
      end
   end

   assert property (@(posedge Clock) disable iff (!nReset)
      Ctrl.flagWe |-> !$isunknown(Result));

endmodule

//--- design/cpuCore.sv
`timescale 1ns/100ps

module cpuCore import cpuPkg::*; (
   input  logic     Clock,
   input  logic     nReset,
   input  word_t    BusIn,
   output addr_t    BusOut,
   output logic     Ale,
   output logic     nMe,
   output logic     nOe,
   output logic     nWe,
   output logic     Enb,
   output logic     WbValid,
   output regAddr_t WbAddr,
   output word_t    WbData,
   output logic     WbCarry
);

   word_t    instr;
   ctrl_t    ctrl;
   busCtrl_t bus;
   logic     execute;
   regAddr_t rd;
   regAddr_t rs1;
   regAddr_t rs2;
   word_t    readData1;
   word_t    readData2;
   word_t    result;
   logic     carry;

   // Register fields of the held instruction
   assign rd  = instr[RdMsb:RdLsb];
   assign rs1 = instr[Rs1Msb:Rs1Lsb];
   assign rs2 = instr[Rs2Msb:Rs2Lsb];

   sequencer uSequencer (.Clock, .nReset, .Instr(instr), .Ctrl(ctrl), .Bus(bus),
                         .Execute(execute));

   fetchUnit uFetchUnit (.Clock, .nReset, .Bus(bus), .PcWe(ctrl.pcWe), .BusIn,
                         .BusOut, .Instr(instr));

   aluUnit uAluUnit (.Clock, .nReset, .Ctrl(ctrl), .Instr(instr), .ReadData1(readData1),
                     .ReadData2(readData2), .Result(result), .Carry(carry));

   registerFile uRegisterFile (.Clock, .nReset, .Ctrl(ctrl), .Rd(rd), .Rs1(rs1), .Rs2(rs2),
                               .WriteData(result), .ReadData1(readData1),
                               .ReadData2(readData2));

   assign Ale = bus.ale;
   assign nMe = bus.nME;
   assign nOe = bus.nOE;
   assign nWe = bus.nWE;
   assign Enb = bus.enb;

   // Write trace, valid in exe1
   assign WbValid = ctrl.regWe;
   assign WbAddr  = rd;
   assign WbData  = result;
   assign WbCarry = carry;

   // Every execute cycle advances the PC and the next fetch starts at once
   assert property (@(posedge Clock) disable iff (!nReset)
      execute |-> ctrl.pcWe ##1 Ale);

endmodule

//--- design/cpuPkg.sv
package cpuPkg;

   typedef logic [15:0] word_t;
   typedef logic [15:0] addr_t;
   typedef logic [2:0]  regAddr_t;

   // Opcode in instruction bits 15..11
   typedef enum logic [4:0] {
      ADD   = 5'd0,
      ADDI  = 5'd1,
      ADDIB = 5'd2,
      ADC   = 5'd3,
      ADCI  = 5'd4
   } opcode_t;

   typedef enum logic {
      FnNOP,
      FnADD
   } aluFunc_t;

   // Execute controls, all from the exe1 decode
   typedef struct packed {
      aluFunc_t aluFunc;
      logic     op2Sel;   // Register or immediate
      logic     immSel;   // Sign-extended imm5 or zero-extended imm8
      logic     useCarry;
      logic     rs1Sel;   // Read port 1 takes rd
      logic     regWe;
      logic     flagWe;
      logic     pcWe;
   } ctrl_t;

   // Bus strobes plus the fetch-side enables
   typedef struct packed {
      logic ale;
      logic nME;
      logic nOE;
      logic nWE;
      logic enb;
      logic pcEn;
      logic irWe;
   } busCtrl_t;

   localparam logic Op2Reg   = 1'b0;
   localparam logic Op2Imm   = 1'b1;
   localparam logic ImmSext5 = 1'b0;
   localparam logic ImmZext8 = 1'b1;

   // Instruction field positions
   localparam int OpMsb   = 15;
   localparam int OpLsb   = 11;
   localparam int RdMsb   = 10;
   localparam int RdLsb   = 8;
   localparam int Rs1Msb  = 7;
   localparam int Rs1Lsb  = 5;
   localparam int Rs2Msb  = 4;
   localparam int Rs2Lsb  = 2;
   localparam int Imm5Msb = 4;
   localparam int Imm8Msb = 7;

   localparam int NumRegs = 8;

endpackage

//--- design/fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit import cpuPkg::*; (
   input  logic     Clock,
   input  logic     nReset,
   input  busCtrl_t Bus,
   input  logic     PcWe,
   input  word_t    BusIn,
   output addr_t    BusOut,
   output word_t    Instr
);

   addr_t pc;
   word_t dataLatch;
   word_t instrReg;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= '0;
      end else if (PcWe) begin
         pc <= pc + addr_t'(1);
      end
   end

   // Captures the memory word at the end of fet3
   always_ff @(posedge Clock) begin
      if (Bus.enb) begin
         dataLatch <= BusIn;
      end
   end

   always_ff @(posedge Clock) begin
      if (Bus.irWe) begin
         instrReg <= dataLatch;
      end
   end

   assign BusOut = Bus.pcEn ? pc : '0;   // Address phase only
   assign Instr  = instrReg;

   // Address and read phases never overlap
   assert property (@(posedge Clock) disable iff (!nReset)
      !(Bus.ale && !Bus.nOE));

endmodule

//--- design/registerFile.sv
`timescale 1ns/100ps

module registerFile import cpuPkg::*; (
   input  logic     Clock,
   input  logic     nReset,
   input  ctrl_t    Ctrl,
   input  regAddr_t Rd,
   input  regAddr_t Rs1,
   input  regAddr_t Rs2,
   input  word_t    WriteData,
   output word_t    ReadData1,
   output word_t    ReadData2
);

   word_t    regs [NumRegs];
   regAddr_t readAddr1;

   // ADDIB reads its own destination
   assign readAddr1 = Ctrl.rs1Sel ? Rd : Rs1;

   assign ReadData1 = regs[readAddr1];
   assign ReadData2 = regs[Rs2];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (Ctrl.regWe) begin
         regs[Rd] <= WriteData;
      end
   end

endmodule

//--- design/sequencer.sv
`timescale 1ns/100ps

module sequencer import cpuPkg::*; (
   input  logic     Clock,
   input  logic     nReset,
   input  word_t    Instr,
   output ctrl_t    Ctrl,
   output busCtrl_t Bus,
   output logic     Execute
);

   typedef enum logic {
      StFetch,
      StExecute
   } state_t;

   typedef enum logic [1:0] {
      Fet1,
      Fet2,
      Fet3,
      Fet4
   } fetchSub_t;

   state_t    state;
   fetchSub_t fetchSub;
   opcode_t   opcode;

   assign opcode  = opcode_t'(Instr[OpMsb:OpLsb]);
   assign Execute = (state == StExecute);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state    <= StFetch;
         fetchSub <= Fet1;
      end else begin
         case (state)
            StFetch: begin
               case (fetchSub)
                  Fet1: fetchSub <= Fet2;
                  Fet2: fetchSub <= Fet3;
                  Fet3: fetchSub <= Fet4;
                  Fet4: begin
                     fetchSub <= Fet1;
                     state    <= StExecute;
                  end
                  default: fetchSub <= Fet1;
               endcase
            end
            StExecute: state <= StFetch;   // Single execute cycle
            default:   state <= StFetch;
         endcase
      end
   end

   // Bus strobes per fetch sub-state
   always_comb begin
      Bus = '{ale: 1'b0, nME: 1'b1, nOE: 1'b1, nWE: 1'b1, enb: 1'b0,
              pcEn: 1'b0, irWe: 1'b0};
      if (state == StFetch) begin
         case (fetchSub)
            Fet1: begin
               Bus.ale  = 1'b1;
               Bus.pcEn = 1'b1;   // PC onto the bus
            end
            Fet2: begin
               Bus.nME = 1'b0;
               Bus.nOE = 1'b0;
            end
            Fet3: begin
               Bus.nME = 1'b0;
               Bus.nOE = 1'b0;
               Bus.enb = 1'b1;    // Latch the read word
            end
            Fet4: Bus.irWe = 1'b1;
            default: ;
         endcase
      end
   end

   // Execute decode
   always_comb begin
      Ctrl = '{aluFunc: FnNOP, op2Sel: Op2Reg, immSel: ImmSext5, useCarry: 1'b0,
               rs1Sel: 1'b0, regWe: 1'b0, flagWe: 1'b0, pcWe: 1'b0};
      if (state == StExecute) begin
         Ctrl.pcWe = 1'b1;
         if (opcode inside {ADD, ADDI, ADDIB, ADC, ADCI}) begin
            Ctrl.aluFunc = FnADD;
            Ctrl.regWe   = 1'b1;
            Ctrl.flagWe  = 1'b1;
         end
         case (opcode)
            ADDI: Ctrl.op2Sel = Op2Imm;
            ADDIB: begin
               Ctrl.op2Sel = Op2Imm;
               Ctrl.immSel = ImmZext8;
               Ctrl.rs1Sel = 1'b1;   // rd is also the source
            end
            ADC: Ctrl.useCarry = 1'b1;
            ADCI: begin
               Ctrl.op2Sel   = Op2Imm;
               Ctrl.useCarry = 1'b1;
            end
            default: ;   // ADD and undefined use the defaults
         endcase
      end
   end

   // Instruction register loads once, right before execute
   assert property (@(posedge Clock) disable iff (!nReset)
      Bus.irWe |-> fetchSub == Fet4 ##1 Execute);

   assert property (@(posedge Clock) disable iff (!nReset)
      Ctrl.regWe |-> Execute ##1 Bus.ale);

endmodule

//--- dv/cpuCoreTb.sv
`timescale 1ns/100ps

module cpuCoreTb import cpuPkg::*; ();

   localparam int          ProgWords     = 256;
   localparam int          NumDirected   = 8;
   localparam int          TimeoutCycles = 10;
   localparam logic [31:0] Seed          = 32'he41e_c8d9;

   typedef struct packed {
      logic     valid;
      regAddr_t addr;
      word_t    data;
      logic     carry;
   } wbExp_t;

   logic Clock;
   logic nReset;
   word_t BusIn, WbData;
   addr_t BusOut;
   logic Ale, nMe, nOe, nWe, Enb, WbValid, WbCarry;
   regAddr_t WbAddr;

   word_t prog [ProgWords];
   word_t refRegs [8];
   logic refCarry;
   logic [31:0] rnd;
   int checkCount = 0;
   int errorCount = 0;

   cpuCore DUT (.Clock, .nReset, .BusIn, .BusOut, .Ale, .nMe, .nOe, .nWe, .Enb,
                .WbValid, .WbAddr, .WbData, .WbCarry);

   sysBusMemory uMemory (.Clock, .Ale, .nMe, .nOe, .Address(BusOut), .Data(BusIn));

   always #4 Clock = ~Clock;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Mostly kept opcodes, one in eight undefined
   function automatic word_t randomInstr(input logic [31:0] r);
      logic [4:0] op;
      case (r[2:0])
         3'd7:       op = 5'd5 + 5'(r[7:3] % 27);
         3'd5, 3'd6: op = 5'(r[7:3] % 5);
         default:    op = {2'b00, r[2:0]};
      endcase
      return {op, r[26:16]};
   endfunction

   // Sets the carry, uses it, and keeps it across an undefined opcode
   function automatic word_t directedInstr(input int i);
      case (i)
         0:       return 16'h11FF;   // ADDIB r1, 0xFF
         1:       return 16'h0A1F;   // ADDI r2, r0, -1
         2:       return 16'h0348;   // ADD r3, r2, r2
         3:       return 16'h1C00;   // ADC r4, r0, r0
         4:       return 16'h0D41;   // ADDI r5, r2, 1
         5:       return 16'hF800;   // Undefined
         6:       return 16'h2600;   // ADCI r6, r0, 0
         default: return 16'h1F00;   // ADC r7, r0, r0
      endcase
   endfunction

   function automatic wbExp_t refExecute(input word_t instr);
      logic [4:0] op;
      regAddr_t rd;
      word_t a, b;
      logic cin;
      logic [16:0] total;
      op  = instr[15:11];
      rd  = instr[10:8];
      a   = refRegs[instr[7:5]];
      b   = {{11{instr[4]}}, instr[4:0]};
      cin = 1'b0;
      case (op)
         5'd0: b = refRegs[instr[4:2]];
         5'd1: ;
         5'd2: begin
            a = refRegs[rd];
            b = {8'h00, instr[7:0]};
         end
         5'd3: begin
            b   = refRegs[instr[4:2]];
            cin = refCarry;
         end
         5'd4: cin = refCarry;
         default: return '0;   // No write, state untouched
      endcase
      total = {1'b0, a} + {1'b0, b} + 17'(cin);
      refRegs[rd] = total[15:0];
      refCarry = total[16];
      return '{valid: 1'b1, addr: rd, data: total[15:0], carry: total[16]};
   endfunction

   task automatic reportError(input string msg);
      errorCount++;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic checkWord(input string name, input word_t got, input word_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkBusAddr(input string name, input addr_t got, input addr_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkRegAddr(input string name, input regAddr_t got, input regAddr_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   // Entered at the negedge of fet1, returns at the next fet1
   task automatic stepInstruction(input int idx, output logic timedOut);
      wbExp_t expected;
      int n;
      logic seenWb;
      logic readPhase;
      seenWb = 1'b0;
      checkBit("Ale", Ale, 1'b1);
      checkBit("Enb", Enb, 1'b0);
      checkBit("nOe", nOe, 1'b1);
      checkBit("nMe", nMe, 1'b1);
      checkBusAddr("BusOut", BusOut, addr_t'(idx));
      expected = refExecute(prog[idx]);
      @(negedge Clock);
      n = 1;
      while (!Ale && n < TimeoutCycles) begin
         readPhase = (n == 1 || n == 2);   // fet2 and fet3
         checkBit("nWe", nWe, 1'b1);
         checkBit("nOe", nOe, !readPhase);
         checkBit("nMe", nMe, !readPhase);
         checkBit("Enb", Enb, n == 2);
         if (WbValid) begin
            seenWb = 1'b1;
            if (!expected.valid) begin
               reportError($sformatf("write trace from undefined opcode at %0d", idx));
            end else begin
               checkRegAddr("WbAddr", WbAddr, expected.addr);
               checkWord("WbData", WbData, expected.data);
               checkBit("WbCarry", WbCarry, expected.carry);
            end
         end
         @(negedge Clock);
         n++;
      end
      timedOut = !Ale;
      if (Ale && n != 5) begin
         reportError($sformatf("Ale pulses %0d cycles apart after address %0d", n, idx));
      end
      if (Ale && expected.valid && !seenWb) begin
         reportError($sformatf("no write trace for instruction at %0d", idx));
      end
   endtask

   initial begin
      Clock  = 1'b0;
      nReset = 1'b0;
      rnd    = Seed;
      for (int i = 0; i < ProgWords; i++) begin
         if (i < NumDirected) begin
            prog[i] = directedInstr(i);
         end else begin
            rnd = xorshift(rnd);
            prog[i] = randomInstr(rnd);
         end
         uMemory.mem[i] = prog[i];
      end
      repeat (2) @(posedge Clock);
      nReset <= 1'b1;
   end

   initial begin : compareProcess
      int n;
      int idx;
      int lastErrors;
      logic timedOut;
      foreach (refRegs[i]) refRegs[i] = '0;
      refCarry = 1'b0;
      timedOut = 1'b0;
      n = 0;
      @(negedge Clock);
      while (!nReset && n < TimeoutCycles) begin
         checkBit("nWe", nWe, 1'b1);
         checkBit("nOe", nOe, 1'b1);
         checkBit("nMe", nMe, 1'b1);
         checkBit("WbValid", WbValid, 1'b0);
         @(negedge Clock);
         n++;
      end
      if (!nReset) begin
         timedOut = 1'b1;
         $display("Reset never released");
      end
      $display("Test reset state done, %0d errors", errorCount);
      lastErrors = errorCount;
      idx = 0;
      while (!timedOut && idx < ProgWords) begin
         stepInstruction(idx, timedOut);
         if (timedOut) begin
            $display("Timed out waiting for Ale after address %0d", idx);
         end
         idx++;
         if (idx == NumDirected) begin
            $display("Test directed carry done, %0d errors", errorCount - lastErrors);
            lastErrors = errorCount;
         end
      end
      $display("Test random program done, %0d errors", errorCount - lastErrors);
      $display("Checks %0d, errors %0d", checkCount, errorCount);
      if (errorCount == 0 && !timedOut) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- dv/sysBusMemory.sv
`timescale 1ns/100ps

module sysBusMemory import cpuPkg::*; (
   input  logic  Clock,
   input  logic  Ale,
   input  logic  nMe,
   input  logic  nOe,
   input  addr_t Address,
   output word_t Data
);

   word_t mem [256];   // Filled by the testbench
   addr_t addrLatch;

   always @(posedge Clock) begin
      if (Ale) begin
         addrLatch <= Address;
      end
   end

   // Drives the bus only during the read phase
   assign Data = (!nMe && !nOe) ? mem[addrLatch[7:0]] : 'z;

endmodule
